// File: common/aluPkg.sv
/* ALU peripheral shared definitions
   Widths, register map, control word layout and AXI response codes */
package aluPkg;

    // Datapath and bus widths
    localparam int DataWidth = 16;
    localparam int AddrWidth = 5;
    localparam int BusWidth = 32;
    localparam int BusStrbWidth = BusWidth / 8;
    localparam int StrbWidth = DataWidth / 8;

    // Register byte addresses
    localparam logic [AddrWidth-1:0] AddrX = 5'h00;
    localparam logic [AddrWidth-1:0] AddrY = 5'h04;
    localparam logic [AddrWidth-1:0] AddrCtrl = 5'h08;
    localparam logic [AddrWidth-1:0] AddrResult = 5'h0C;
    localparam logic [AddrWidth-1:0] AddrFlags = 5'h10;

    // Function controls, same order as the classic six-bit ALU
    localparam int CtrlNo = 0;
    localparam int CtrlF = 1;
    localparam int CtrlNy = 2;
    localparam int CtrlEy = 3;
    localparam int CtrlNx = 4;
    localparam int CtrlEx = 5;

    localparam int CtrlShr8 = 6;

    // Two-bit write-back destination field starts here
    localparam int CtrlDstLo = 7;
    localparam int DstWidth = 2;

    localparam logic [DstWidth-1:0] DstNone = 2'd0;
    localparam logic [DstWidth-1:0] DstX = 2'd1;
    localparam logic [DstWidth-1:0] DstY = 2'd2;

    localparam int CtrlWidth = 9;

    localparam logic [1:0] RespOkay = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

endpackage

// File: alu/hackAlu.sv
/* Six-bit controlled ALU function unit
   Operand enable and invert, add or and, output invert, flags, shift by eight */
`timescale 1ns/1ns

module hackAlu
    import aluPkg::*;
(
    input  logic [DataWidth-1:0] opX,
    input  logic [DataWidth-1:0] opY,
    input  logic [CtrlWidth-1:0] ctrlWord,
    output logic [DataWidth-1:0] aluOut,
    output logic                 zFlag,
    output logic                 ltFlag
);

    logic [DataWidth-1:0] xEnabled;
    logic [DataWidth-1:0] yEnabled;
    logic [DataWidth-1:0] xIn;
    logic [DataWidth-1:0] yIn;
    logic [DataWidth-1:0] funcOut;
    logic [DataWidth-1:0] rawOut;

    // Cleared enable zeroes the operand
    assign xEnabled = ctrlWord[CtrlEx] ? opX : '0;
    assign yEnabled = ctrlWord[CtrlEy] ? opY : '0;

    assign xIn = ctrlWord[CtrlNx] ? ~xEnabled : xEnabled;
    assign yIn = ctrlWord[CtrlNy] ? ~yEnabled : yEnabled;

    // Sum wraps modulo 2^16
    assign funcOut = ctrlWord[CtrlF] ? (xIn + yIn) : (xIn & yIn);

    assign rawOut = ctrlWord[CtrlNo] ? ~funcOut : funcOut;

    // Flags always describe the value before the shift
    assign zFlag = (rawOut == '0);
    assign ltFlag = rawOut[DataWidth-1];

    assign aluOut = ctrlWord[CtrlShr8] ? (rawOut >> 8) : rawOut;

endmodule

// File: source/operandRegs.sv
/* X and Y operand registers
   Byte-strobed bus writes plus ALU result write-back on execute */
`timescale 1ns/1ns

module operandRegs
    import aluPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 writeX,
    input  logic                 writeY,
    input  logic [DataWidth-1:0] writeData,
    input  logic [StrbWidth-1:0] writeStrb,
    input  logic                 execute,
    input  logic [CtrlWidth-1:0] ctrlWord,
    input  logic [DataWidth-1:0] aluOut,
    output logic [DataWidth-1:0] opX,
    output logic [DataWidth-1:0] opY
);

    logic [DstWidth-1:0] dstSel;
    logic                writeBack;

    function automatic logic [DataWidth-1:0] mergeBytes(
        input logic [DataWidth-1:0] oldValue,
        input logic [DataWidth-1:0] newValue,
        input logic [StrbWidth-1:0] strb
    );
        logic [DataWidth-1:0] merged;
        merged = oldValue;
        for (int b = 0; b < StrbWidth; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = newValue[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign dstSel = ctrlWord[CtrlDstLo +: DstWidth];
    assign writeBack = execute && (dstSel != DstNone);

    // aluOut already carries the shift, so write-back matches RESULT
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opX <= '0;
            opY <= '0;
        end else begin
            if (writeX) begin
                opX <= mergeBytes(opX, writeData, writeStrb);
            end else if (writeBack && dstSel == DstX) begin
                opX <= aluOut;
            end
            if (writeY) begin
                opY <= mergeBytes(opY, writeData, writeStrb);
            end else if (writeBack && dstSel == DstY) begin
                opY <= aluOut;
            end
        end
    end

endmodule

// File: source/resultUnit.sv
/* Result and flag registers
   Capture the ALU output on execute and hold it for reads */
`timescale 1ns/1ns

module resultUnit
    import aluPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 execute,
    input  logic [DataWidth-1:0] aluOut,
    input  logic                 zFlag,
    input  logic                 ltFlag,
    output logic [DataWidth-1:0] result,
    output logic                 flagsZ,
    output logic                 flagsLt
);

    // Held until the next execute, later operand writes do not disturb it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
            flagsZ <= 1'b0;
            flagsLt <= 1'b0;
        end else if (execute) begin
            result <= aluOut;
            flagsZ <= zFlag;
            flagsLt <= ltFlag;
        end
    end

endmodule

// File: source/aluControl.sv
/* AXI4-Lite slave for the ALU peripheral
   Runs the handshakes, decodes the register map and muxes read data */
`timescale 1ns/1ns

module aluControl
    import aluPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [AddrWidth-1:0]    awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [BusWidth-1:0]     wdata,
    input  logic [BusStrbWidth-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [AddrWidth-1:0]    araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [BusWidth-1:0]     rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  logic [DataWidth-1:0]    opX,
    input  logic [DataWidth-1:0]    opY,
    input  logic [DataWidth-1:0]    result,
    input  logic                    zFlag,
    input  logic                    ltFlag,
    output logic                    writeX,
    output logic                    writeY,
    output logic [DataWidth-1:0]    writeData,
    output logic [StrbWidth-1:0]    writeStrb,
    output logic                    execute,
    output logic [CtrlWidth-1:0]    ctrlWord
);

    logic                writeAccept;
    logic                writeKnown;
    logic                readAccept;
    logic                readKnown;
    logic [BusWidth-1:0] readMux;

    // Address and data are taken together, one write in flight at most
    assign writeAccept = awvalid && wvalid && !bvalid;
    assign awready = writeAccept;
    assign wready = writeAccept;

    assign writeX = writeAccept && (awaddr == AddrX);
    assign writeY = writeAccept && (awaddr == AddrY);
    assign execute = writeAccept && (awaddr == AddrCtrl);
    assign writeKnown = (awaddr == AddrX) || (awaddr == AddrY) || (awaddr == AddrCtrl);

    // Upper half of the bus word is ignored
    assign writeData = wdata[DataWidth-1:0];
    assign writeStrb = wstrb[StrbWidth-1:0];
    assign ctrlWord = wdata[CtrlWidth-1:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bvalid <= 1'b0;
        end else if (writeAccept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (writeAccept) begin
            bresp <= writeKnown ? RespOkay : RespSlvErr;
        end
    end

    assign readAccept = arvalid && !rvalid;
    assign arready = readAccept;

    always_comb begin
        readMux = '0;
        readKnown = 1'b1;
        case (araddr)
            AddrX:      readMux[DataWidth-1:0] = opX;
            AddrY:      readMux[DataWidth-1:0] = opY;
            AddrResult: readMux[DataWidth-1:0] = result;
            // Z in bit 0, LT in bit 1
            AddrFlags:  readMux[1:0] = {ltFlag, zFlag};
            default:    readKnown = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rvalid <= 1'b0;
        end else if (readAccept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Sampled once at acceptance, stable while rvalid waits
    always_ff @(posedge clk) begin
        if (readAccept) begin
            rdata <= readMux;
            rresp <= readKnown ? RespOkay : RespSlvErr;
        end
    end

endmodule

// File: source/aluTop.sv
/* ALU peripheral top level
   Connects the AXI4-Lite slave to the operand, function and result blocks */
`timescale 1ns/1ns

module aluTop
    import aluPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [AddrWidth-1:0]    awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [BusWidth-1:0]     wdata,
    input  logic [BusStrbWidth-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [AddrWidth-1:0]    araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [BusWidth-1:0]     rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    logic                 writeX;
    logic                 writeY;
    logic                 execute;
    logic [DataWidth-1:0] writeData;
    logic [StrbWidth-1:0] writeStrb;
    logic [CtrlWidth-1:0] ctrlWord;
    logic [DataWidth-1:0] opX;
    logic [DataWidth-1:0] opY;
    logic [DataWidth-1:0] aluOut;
    logic                 zFlag;
    logic                 ltFlag;
    logic [DataWidth-1:0] result;
    logic                 flagsZ;
    logic                 flagsLt;

    aluControl u_aluControl (
        .clk       (clk),
        .rstN      (rstN),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .opX       (opX),
        .opY       (opY),
        .result    (result),
        .zFlag     (flagsZ),
        .ltFlag    (flagsLt),
        .writeX    (writeX),
        .writeY    (writeY),
        .writeData (writeData),
        .writeStrb (writeStrb),
        .execute   (execute),
        .ctrlWord  (ctrlWord)
    );

    operandRegs u_operandRegs (
        .clk       (clk),
        .rstN      (rstN),
        .writeX    (writeX),
        .writeY    (writeY),
        .writeData (writeData),
        .writeStrb (writeStrb),
        .execute   (execute),
        .ctrlWord  (ctrlWord),
        .aluOut    (aluOut),
        .opX       (opX),
        .opY       (opY)
    );

    hackAlu u_hackAlu (
        .opX      (opX),
        .opY      (opY),
        .ctrlWord (ctrlWord),
        .aluOut   (aluOut),
        .zFlag    (zFlag),
        .ltFlag   (ltFlag)
    );

    resultUnit u_resultUnit (
        .clk     (clk),
        .rstN    (rstN),
        .execute (execute),
        .aluOut  (aluOut),
        .zFlag   (zFlag),
        .ltFlag  (ltFlag),
        .result  (result),
        .flagsZ  (flagsZ),
        .flagsLt (flagsLt)
    );

endmodule

// File: verification/aluAxi_assert.sv
/* AXI4-Lite handshake assertions for the ALU slave */
`timescale 1ns/1ns

module aluAxiAssert
    import aluPkg::*;
(
    input logic                clk,
    input logic                rstN,
    input logic                awvalid,
    input logic                awready,
    input logic                wready,
    input logic [1:0]          bresp,
    input logic                bvalid,
    input logic                bready,
    input logic [BusWidth-1:0] rdata,
    input logic [1:0]          rresp,
    input logic                rvalid,
    input logic                rready
);

    int failures = 0;

    // Valid and payload held until the transfer
    bHeld: assert property (@(posedge clk) disable iff (!rstN)
        bvalid && !bready |=> bvalid && $stable(bresp)) else begin
        failures++;
        $error("bvalid dropped or bresp changed before bready");
    end

    rHeld: assert property (@(posedge clk) disable iff (!rstN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)) else begin
        failures++;
        $error("rvalid dropped or read payload changed before rready");
    end

    readyTogether: assert property (@(posedge clk) disable iff (!rstN)
        awready == wready) else begin
        failures++;
        $error("awready and wready differ");
    end

    bAfterAccept: assert property (@(posedge clk) disable iff (!rstN)
        awvalid && awready |=> $rose(bvalid)) else begin
        failures++;
        $error("bvalid did not rise one cycle after write acceptance");
    end

endmodule

// File: verification/aluChecker.sv
/* Response checker for the ALU peripheral
   Compares write responses and read data with the address map and the stimulus file */
`timescale 1ns/1ns

module aluChecker
    import aluPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [AddrWidth-1:0] awaddr,
    input  logic                 awvalid,
    input  logic                 awready,
    input  logic [1:0]           bresp,
    input  logic                 bvalid,
    input  logic                 bready,
    input  logic [AddrWidth-1:0] araddr,
    input  logic                 arvalid,
    input  logic                 arready,
    input  logic [BusWidth-1:0]  rdata,
    input  logic [1:0]           rresp,
    input  logic                 rvalid,
    input  logic                 rready,
    output int                   checkerErrors,
    output int                   linesChecked
);

    int                   fd = 0;
    int                   errors = 0;
    int                   lines = 0;
    bit                   haveLine = 1'b0;
    logic [DataWidth-1:0] expResult;
    logic [1:0]           expFlags;
    logic [AddrWidth-1:0] wrAddr;
    logic [AddrWidth-1:0] rdAddr;

    assign checkerErrors = errors;
    assign linesChecked = lines;

    task automatic loadLine();
        string line;
        int mode;
        logic [DataWidth-1:0] x;
        logic [DataWidth-1:0] y;
        logic [CtrlWidth-1:0] ctrl;
        haveLine = 1'b0;
        while (!haveLine && fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            haveLine = ($sscanf(line, "%h %h %h %h %h %h",
                                mode, x, y, ctrl, expResult, expFlags) == 6);
        end
    endtask

    task automatic compare(input string name, input logic [AddrWidth-1:0] addr,
                           input logic [BusWidth-1:0] expected, input logic [BusWidth-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s at address 0x%h: expected 0x%h, got 0x%h",
                     name, addr, expected, actual);
            errors++;
        end
    endtask

    // Operand and result registers all hold the expected result column
    function automatic logic [BusWidth-1:0] expectedRead(input logic [AddrWidth-1:0] addr);
        case (addr)
            AddrX, AddrY, AddrResult: return BusWidth'(expResult);
            AddrFlags: return BusWidth'(expFlags);
            default: return '0;
        endcase
    endfunction

    function automatic logic [1:0] expectedResp(input logic [AddrWidth-1:0] addr, input bit isWrite);
        if (addr == AddrX || addr == AddrY) begin
            return RespOkay;
        end
        if (isWrite) begin
            return (addr == AddrCtrl) ? RespOkay : RespSlvErr;
        end
        return (addr == AddrResult || addr == AddrFlags) ? RespOkay : RespSlvErr;
    endfunction

    always @(posedge clk) begin
        if (!rstN) begin
            if (fd == 0) begin
                fd = $fopen("verification/alu_stimulus.txt", "r");
                loadLine();
            end
        end else begin
            if (awvalid && awready) begin
                wrAddr = awaddr;
            end
            if (bvalid && bready) begin
                compare("bresp", wrAddr, BusWidth'(expectedResp(wrAddr, 1'b1)), BusWidth'(bresp));
            end
            if (arvalid && arready) begin
                rdAddr = araddr;
            end
            if (rvalid && rready) begin
                if (!haveLine) begin
                    $display("A read response came back after the last stimulus line");
                    errors++;
                end
                compare("rresp", rdAddr, BusWidth'(expectedResp(rdAddr, 1'b0)), BusWidth'(rresp));
                compare("rdata", rdAddr, expectedRead(rdAddr), rdata);
                // FLAGS is always the last read of a line
                if (rdAddr == AddrFlags) begin
                    lines++;
                    loadLine();
                end
            end
        end
    end

endmodule

// File: verification/aluTb.sv
/* ALU peripheral testbench
   Replays the stimulus file as AXI4-Lite writes and reads */
`timescale 1ns/1ns

module aluTb
    import aluPkg::*;
();

    localparam int Timeout = 50;
    localparam int Seed = 75947;
    localparam logic [AddrWidth-1:0] AddrUnknown = 5'h14;

    logic                    clk;
    logic                    rstN;
    logic [AddrWidth-1:0]    awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [BusWidth-1:0]     wdata;
    logic [BusStrbWidth-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [AddrWidth-1:0]    araddr;
    logic                    arvalid;
    logic                    arready;
    logic [BusWidth-1:0]     rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    int                      checkerErrors;
    int                      linesChecked;
    int                      linesRun;
    int                      tbErrors;
    bit                      hung;

    aluTop u_aluTop (.*);

    aluChecker u_aluChecker (.*);

    bind aluControl aluAxiAssert u_axiAssert (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic giveUp(input string what);
        $display("Timeout: %s", what);
        tbErrors++;
        hung = 1'b1;
    endtask

    task automatic axiWrite(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                            input logic [BusStrbWidth-1:0] strb);
        int cycles;
        int stall;
        if (hung) begin
            return;
        end
        awaddr <= addr;
        awvalid <= 1'b1;
        // Upper half carries junk, the slave must ignore it
        wdata <= {~data, data};
        wstrb <= strb;
        wvalid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!awready && cycles < Timeout);
        if (!awready) begin
            giveUp("write address and data were never accepted");
            return;
        end
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        stall = $urandom % 4;
        repeat (stall) @(posedge clk);
        bready <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!bvalid && cycles < Timeout);
        bready <= 1'b0;
        if (!bvalid) begin
            giveUp("no write response arrived");
        end
    endtask

    task automatic axiRead(input logic [AddrWidth-1:0] addr);
        int cycles;
        int stall;
        if (hung) begin
            return;
        end
        araddr <= addr;
        arvalid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!arready && cycles < Timeout);
        if (!arready) begin
            giveUp("read address was never accepted");
            return;
        end
        arvalid <= 1'b0;
        stall = $urandom % 4;
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rvalid && cycles < Timeout);
        rready <= 1'b0;
        if (!rvalid) begin
            giveUp("no read data arrived");
        end
    endtask

    // One operation, then RESULT, the write-back target and FLAGS
    task automatic runOp(input logic [CtrlWidth-1:0] ctrl);
        logic [DstWidth-1:0] dst;
        dst = ctrl[CtrlDstLo +: DstWidth];
        axiWrite(AddrCtrl, DataWidth'(ctrl), 4'hF);
        axiRead(AddrResult);
        if (dst == DstX) begin
            axiRead(AddrX);
        end else if (dst == DstY) begin
            axiRead(AddrY);
        end
        axiRead(AddrFlags);
    endtask

    task automatic runLine(input int mode, input logic [DataWidth-1:0] x,
                           input logic [DataWidth-1:0] y, input logic [CtrlWidth-1:0] ctrl);
        case (mode)
            0: begin
                axiWrite(AddrX, x, 4'hF);
                axiWrite(AddrY, y, 4'hF);
                runOp(ctrl);
            end
            1: runOp(ctrl);
            // Control column holds the byte strobes here
            2: begin
                axiWrite(AddrX, x, 4'hF);
                axiWrite(AddrX, y, ctrl[3:0]);
                axiRead(AddrX);
                axiRead(AddrFlags);
            end
            default: begin
                axiWrite(AddrResult, x, 4'hF);
                axiWrite(AddrFlags, x, 4'hF);
                axiWrite(AddrUnknown, y, 4'hF);
                axiRead(AddrResult);
                axiRead(AddrUnknown);
                axiRead(AddrFlags);
            end
        endcase
    endtask

    task automatic finishRun();
        int assertErrors;
        assertErrors = u_aluTop.u_aluControl.u_axiAssert.failures;
        if (linesRun == 0 || linesChecked != linesRun) begin
            $display("Checker finished %0d of %0d stimulus lines", linesChecked, linesRun);
            tbErrors++;
        end
        $display("Errors: checker %0d, assertions %0d, testbench %0d",
                 checkerErrors, assertErrors, tbErrors);
        if (checkerErrors + assertErrors + tbErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        int fd;
        string line;
        int mode;
        logic [DataWidth-1:0] x;
        logic [DataWidth-1:0] y;
        logic [CtrlWidth-1:0] ctrl;
        void'($urandom(Seed));
        rstN <= 1'b0;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b0;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b0;
        linesRun = 0;
        tbErrors = 0;
        hung = 1'b0;
        fd = $fopen("verification/alu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
        end
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        while (fd != 0 && !hung && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %h", mode, x, y, ctrl) == 4) begin
                runLine(mode, x, y, ctrl);
                linesRun++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        finishRun();
    end

endmodule

// File: verification/alu_stimulus.txt
# mode x y ctrl expResult expFlags, all hex; flags bit 0 is Z, bit 1 is LT
# mode 0 loads X and Y, 1 reuses them, 2 strobes a write to X, 3 writes read-only addresses
3 BEEF CAFE 000 0000 0
0 1234 0F0F 02A 2143 0
0 1234 0F0F 03B 0325 0
0 1234 0F0F 02F FCDB 2
0 1234 0F0F 037 1235 0
0 1234 0F0F 01F 0F10 0
0 1234 0F0F 026 1233 0
0 1234 0F0F 01A 0F0E 0
0 1234 0F0F 027 EDCC 2
0 1234 0F0F 01B F0F1 2
0 1234 0F0F 028 0204 0
0 1234 0F0F 03D 1F3F 0
0 1234 0F0F 025 EDCB 2
0 1234 0F0F 019 F0F0 2
0 1234 0F0F 024 1234 0
0 1234 0F0F 018 0F0F 0
0 1234 0F0F 002 0000 1
0 1234 0F0F 017 0001 0
0 1234 0F0F 012 FFFF 2
0 0F0F 1234 07B 00FC 2
0 00AB 0000 064 0000 0
0 0100 0023 0AA 0123 0
1 0000 0000 12A 0146 0
1 0000 0000 03B FFDD 2
1 0000 0000 0D8 0001 0
2 A5C3 1E77 002 1EC3 0
2 A5C3 1E77 001 A577 0
3 BEEF CAFE 000 0001 0

// File: run.sh
#!/bin/sh
# Build and run the ALU peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module aluTb -Mdir build/obj_dir -o aluSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/obj_dir/aluSim +verilator+error+limit+1000 > build/sim.log 2>&1
status=$?
cat build/sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" build/sim.log; then
    exit 0
fi
echo "Pass message not found in build/sim.log"
exit 1

// File: all.f
common/aluPkg.sv
alu/hackAlu.sv
source/operandRegs.sv
source/resultUnit.sv
source/aluControl.sv
source/aluTop.sv
verification/aluAxi_assert.sv
verification/aluChecker.sv
verification/aluTb.sv
